/* hdl/touch_calib_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface touch_calib_if
	import touch_pkg::*;
();

	// subtracted from raw x and y before scaling
	coord_t offset_x;
	coord_t offset_y;
	// minimum z that counts as a press
	coord_t threshold;
	// raw to screen scale
	shift_t shift;

	// register block owns the values
	modport regs (
		output offset_x,
		output offset_y,
		output threshold,
		output shift
	);

	// lock logic only reads them
	modport lock (
		input offset_x,
		input offset_y,
		input threshold,
		input shift
	);

endinterface

`default_nettype wire

/* hdl/touch_calib_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module touch_calib_regs
	import touch_pkg::*;
(
	input logic tft_new_frame,
	input logic reset,
	input logic cfg_write,
	input cfg_addr_t cfg_addr,
	input coord_t cfg_data,
	touch_calib_if.regs calib
);

	// calibration storage
	coord_t offset_x;
	coord_t offset_y;
	coord_t threshold;
	shift_t shift;

	// new value seen on the frame after the write
	always_ff @(posedge tft_new_frame) begin
		if (reset) begin
			offset_x <= DEFAULT_OFFSET_X;
			offset_y <= DEFAULT_OFFSET_Y;
			threshold <= DEFAULT_THRESHOLD;
			shift <= DEFAULT_SHIFT;
		end else if (cfg_write) begin
			case (cfg_addr)
				CFG_ADDR_OFFSET_X: begin
					offset_x <= cfg_data;
				end
				CFG_ADDR_OFFSET_Y: begin
					offset_y <= cfg_data;
				end
				CFG_ADDR_THRESHOLD: begin
					threshold <= cfg_data;
				end
				CFG_ADDR_SHIFT: begin
					// only two bits of shift are meaningful
					shift <= cfg_data[SHIFT_W-1:0];
				end
			endcase
		end
	end

	// out to the lock stage as plain levels
	assign calib.offset_x = offset_x;
	assign calib.offset_y = offset_y;
	assign calib.threshold = threshold;
	assign calib.shift = shift;

	// a write with a floating address would corrupt an unknown register
	a_addr_known : assert property (
		@(posedge tft_new_frame) disable iff (reset)
		cfg_write |-> !$isunknown(cfg_addr)
	) else $error("touch_calib_regs: cfg_addr unknown during write");

endmodule

`default_nettype wire

/* hdl/touch_frame_top.sv */
`timescale 1ns/10ps
`default_nettype none

module touch_frame_top
	import touch_pkg::*;
(
	// one edge per display frame
	input logic tft_new_frame,
	input logic reset,
	// raw touchpad readings
	input coord_t touch_x,
	input coord_t touch_y,
	input coord_t touch_z,
	// calibration write port
	input logic cfg_write,
	input cfg_addr_t cfg_addr,
	input coord_t cfg_data,
	// cursor, one frame behind the inputs
	output coord_t cursor_x,
	output coord_t cursor_y,
	output logic touched,
	// gestures, two frames behind the inputs
	output logic press,
	output logic release_pulse,
	output hold_count_t hold_frames
);

	// calibration levels into the lock stage
	touch_calib_if calib ();
	// locked sample between the two pipeline stages
	touch_sample_if sample ();

	touch_calib_regs u_calib_regs (
		.tft_new_frame (tft_new_frame),
		.reset (reset),
		.cfg_write (cfg_write),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.calib (calib.regs)
	);

	// stage 1, threshold, offset, scale, hold
	touch_position_lock u_position_lock (
		.tft_new_frame (tft_new_frame),
		.reset (reset),
		.touch_x (touch_x),
		.touch_y (touch_y),
		.touch_z (touch_z),
		.calib (calib.lock),
		.sample (sample.source)
	);

	// stage 2, edges and held-frame count
	touch_press_tracker u_press_tracker (
		.tft_new_frame (tft_new_frame),
		.reset (reset),
		.sample (sample.sink),
		.press (press),
		.release_pulse (release_pulse),
		.hold_frames (hold_frames)
	);

	// cursor straight from the lock stage
	assign cursor_x = sample.locked_x;
	assign cursor_y = sample.locked_y;
	assign touched = sample.touched;

endmodule

`default_nettype wire

/* hdl/touch_pkg.sv */
`default_nettype none

package touch_pkg;

	// touchpad adc resolution, shared by x, y and z
	localparam int COORD_W = 12;
	// scale shift range is 0 to 3
	localparam int SHIFT_W = 2;
	// four calibration registers
	localparam int CFG_ADDR_W = 2;
	// held-frame counter width
	localparam int HOLD_W = 8;

	// raw samples, offsets, threshold and locked positions
	typedef logic [COORD_W-1:0] coord_t;
	// right shift from raw touch scale to screen scale
	typedef logic [SHIFT_W-1:0] shift_t;
	// calibration register address
	typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
	// frames the panel has been held down
	typedef logic [HOLD_W-1:0] hold_count_t;

	// register map
	localparam cfg_addr_t CFG_ADDR_OFFSET_X = 2'd0;
	localparam cfg_addr_t CFG_ADDR_OFFSET_Y = 2'd1;
	localparam cfg_addr_t CFG_ADDR_THRESHOLD = 2'd2;
	localparam cfg_addr_t CFG_ADDR_SHIFT = 2'd3;

	// power-up calibration, measured on the bench panel
	localparam coord_t DEFAULT_OFFSET_X = 12'd150;
	localparam coord_t DEFAULT_OFFSET_Y = 12'd300;
	// a press shows up as z at or above 256
	localparam coord_t DEFAULT_THRESHOLD = 12'd256;
	// divide by 4 to land on the display grid
	localparam shift_t DEFAULT_SHIFT = 2'd2;

	// counter stops here instead of wrapping
	localparam hold_count_t HOLD_COUNT_MAX = {HOLD_W{1'b1}};

endpackage

`default_nettype wire

/* hdl/touch_position_lock.sv */
`timescale 1ns/10ps
`default_nettype none

module touch_position_lock
	import touch_pkg::*;
(
	input logic tft_new_frame,
	input logic reset,
	input coord_t touch_x,
	input coord_t touch_y,
	input coord_t touch_z,
	touch_calib_if.lock calib,
	touch_sample_if.source sample
);

	// pressure test for the current frame
	logic pressed;
	// offset-corrected raw position wraps mod 4096
	coord_t adj_x;
	coord_t adj_y;
	// screen-scaled position
	coord_t scaled_x;
	coord_t scaled_y;

	// registered outputs
	coord_t locked_x;
	coord_t locked_y;
	logic touched;
	coord_t pressure;

	always_comb begin
		pressed = (touch_z >= calib.threshold);
		adj_x = touch_x - calib.offset_x;
		adj_y = touch_y - calib.offset_y;
		// unsigned shift with no sign extension after wrap
		scaled_x = adj_x >> calib.shift;
		scaled_y = adj_y >> calib.shift;
	end

	// touched follows every frame but position only moves while pressed
	always_ff @(posedge tft_new_frame) begin
		if (reset) begin
			touched <= 1'b0;
			locked_x <= '0;
			locked_y <= '0;
		end else begin
			touched <= pressed;
			if (pressed) begin
				locked_x <= scaled_x;
				locked_y <= scaled_y;
			end
		end
	end

	// raw z kept alongside the sample
	always_ff @(posedge tft_new_frame) begin
		pressure <= touch_z;
	end

	assign sample.locked_x = locked_x;
	assign sample.locked_y = locked_y;
	assign sample.touched = touched;
	assign sample.pressure = pressure;

	// cursor must stay put across lift-off
	a_hold_on_release : assert property (
		@(posedge tft_new_frame) disable iff (reset)
		(!$past(reset) && !sample.touched) |->
			($stable(sample.locked_x) && $stable(sample.locked_y))
	) else $error("touch_position_lock: position moved while not touched");

endmodule

`default_nettype wire

/* hdl/touch_press_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module touch_press_tracker
	import touch_pkg::*;
(
	input logic tft_new_frame,
	input logic reset,
	touch_sample_if.sink sample,
	output logic press,
	output logic release_pulse,
	output hold_count_t hold_frames
);

	// touched as seen one frame earlier
	logic touched_d;
	// next counter value
	hold_count_t hold_next;

	always_comb begin
		if (!sample.touched) begin
			hold_next = '0;
		end else if (hold_frames == HOLD_COUNT_MAX) begin
			// long press pins at the top
			hold_next = HOLD_COUNT_MAX;
		end else begin
			hold_next = hold_frames + hold_count_t'(1);
		end
	end

	always_ff @(posedge tft_new_frame) begin
		if (reset) begin
			touched_d <= 1'b0;
			press <= 1'b0;
			release_pulse <= 1'b0;
			hold_frames <= '0;
		end else begin
			touched_d <= sample.touched;
			// rising edge of touched
			press <= sample.touched & ~touched_d;
			// falling edge of touched
			release_pulse <= ~sample.touched & touched_d;
			hold_frames <= hold_next;
		end
	end

	// a single frame cannot be both a press and a release
	a_pulse_exclusive : assert property (
		@(posedge tft_new_frame) disable iff (reset)
		!(press && release_pulse)
	) else $error("touch_press_tracker: press and release together");

	// counter only climbs or drops straight to zero
	a_hold_monotonic : assert property (
		@(posedge tft_new_frame) disable iff (reset)
		(hold_frames >= $past(hold_frames)) || (hold_frames == '0)
	) else $error("touch_press_tracker: hold_frames went backwards");

endmodule

`default_nettype wire

/* hdl/touch_sample_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface touch_sample_if
	import touch_pkg::*;
();

	// last position captured while pressed
	coord_t locked_x;
	coord_t locked_y;
	// panel pressed in the frame just sampled
	logic touched;
	// raw z registered with the sample
	coord_t pressure;

	// driven by the lock stage
	modport source (
		output locked_x,
		output locked_y,
		output touched,
		output pressure
	);

	// consumed by the press tracker
	modport sink (
		input locked_x,
		input locked_y,
		input touched,
		input pressure
	);

endinterface

`default_nettype wire

/* project.f */
hdl/touch_pkg.sv
hdl/touch_calib_if.sv
hdl/touch_sample_if.sv
hdl/touch_calib_regs.sv
hdl/touch_position_lock.sv
hdl/touch_press_tracker.sv
hdl/touch_frame_top.sv
verif/touch_frame_tb.sv

/* verif/touch_frame_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module touch_frame_tb
	import touch_pkg::*;
();

	// frames per test for the watchdog budget
	localparam int TEST_FRAMES = 9 + 4 + 44 + 8 + 317 + 14;
	localparam int MARGIN_FRAMES = 100;
	localparam int FRAME_NS = 100;

	logic tft_new_frame;
	logic reset;
	coord_t touch_x;
	coord_t touch_y;
	coord_t touch_z;
	logic cfg_write;
	cfg_addr_t cfg_addr;
	coord_t cfg_data;
	coord_t cursor_x;
	coord_t cursor_y;
	logic touched;
	logic press;
	logic release_pulse;
	hold_count_t hold_frames;

	int errors = 0;
	logic [31:0] rng_state = 32'hf82d8800;

	// reference calibration and pipeline state
	coord_t m_off_x;
	coord_t m_off_y;
	coord_t m_thr;
	shift_t m_shift;
	coord_t m_lx;
	coord_t m_ly;
	logic m_prev_t;
	hold_count_t m_hold;

	// stage 1 results lag one frame
	coord_t q_cx[$];
	coord_t q_cy[$];
	logic q_t[$];
	// stage 2 results lag two frames
	logic q_press[$];
	logic q_rel[$];
	hold_count_t q_hold[$];

	// gesture tallies for test 4
	int press_seen;
	int release_seen;
	hold_count_t hold_peak;

	touch_frame_top dut (
		.tft_new_frame (tft_new_frame),
		.reset (reset),
		.touch_x (touch_x),
		.touch_y (touch_y),
		.touch_z (touch_z),
		.cfg_write (cfg_write),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.cursor_x (cursor_x),
		.cursor_y (cursor_y),
		.touched (touched),
		.press (press),
		.release_pulse (release_pulse),
		.hold_frames (hold_frames)
	);

	// 100 ns frame
	initial tft_new_frame = 1'b0;
	always #50 tft_new_frame = ~tft_new_frame;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check_coord(input string name, input coord_t exp, input coord_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input hold_count_t exp,
			input hold_count_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	// one frame through the reference rules
	// calibration write lands after the lock
	task automatic advance_model(input coord_t x, input coord_t y, input coord_t z,
			input logic wr, input cfg_addr_t addr, input coord_t data);
		logic t;
		coord_t ax;
		coord_t ay;
		t = (z >= m_thr);
		ax = x - m_off_x;
		ay = y - m_off_y;
		if (t) begin
			m_lx = ax >> m_shift;
			m_ly = ay >> m_shift;
		end
		q_cx.push_back(m_lx);
		q_cy.push_back(m_ly);
		q_t.push_back(t);
		q_press.push_back(t & ~m_prev_t);
		q_rel.push_back(~t & m_prev_t);
		if (!t)
			m_hold = '0;
		else if (m_hold != HOLD_COUNT_MAX)
			m_hold = m_hold + hold_count_t'(1);
		q_hold.push_back(m_hold);
		m_prev_t = t;
		if (wr) begin
			case (addr)
				CFG_ADDR_OFFSET_X: m_off_x = data;
				CFG_ADDR_OFFSET_Y: m_off_y = data;
				CFG_ADDR_THRESHOLD: m_thr = data;
				default: m_shift = data[1:0];
			endcase
		end
	endtask

	// outputs against the frame one back (cursor) and two back (gestures)
	task automatic compare_outputs();
		if (q_t.size() < 1 || q_hold.size() < 2) begin
			errors++;
			$display("reference queues ran empty at %0t, frame bookkeeping is broken", $time);
		end else begin
			check_coord("cursor_x", q_cx.pop_front(), cursor_x);
			check_coord("cursor_y", q_cy.pop_front(), cursor_y);
			check_flag("touched", q_t.pop_front(), touched);
			check_flag("press", q_press.pop_front(), press);
			check_flag("release_pulse", q_rel.pop_front(), release_pulse);
			check_count("hold_frames", q_hold.pop_front(), hold_frames);
		end
		press_seen += press;
		release_seen += release_pulse;
		if (hold_frames > hold_peak)
			hold_peak = hold_frames;
	endtask

	// drive a frame and check mid-frame before feeding the model
	task automatic step(input coord_t x, input coord_t y, input coord_t z,
			input logic wr = 1'b0, input cfg_addr_t addr = '0, input coord_t data = '0);
		@(posedge tft_new_frame);
		touch_x <= x;
		touch_y <= y;
		touch_z <= z;
		cfg_write <= wr;
		cfg_addr <= addr;
		cfg_data <= data;
		@(negedge tft_new_frame);
		compare_outputs();
		advance_model(x, y, z, wr, addr, data);
	endtask

	task automatic apply_reset();
		m_off_x = DEFAULT_OFFSET_X;
		m_off_y = DEFAULT_OFFSET_Y;
		m_thr = DEFAULT_THRESHOLD;
		m_shift = DEFAULT_SHIFT;
		m_lx = '0;
		m_ly = '0;
		m_prev_t = 1'b0;
		m_hold = '0;
		// tracker still in reset on the first frame after release
		q_press.push_back(1'b0);
		q_rel.push_back(1'b0);
		q_hold.push_back('0);
		repeat (8) @(posedge tft_new_frame);
		reset <= 1'b0;
		// idle frame presented on the deassert edge
		advance_model('0, '0, '0, 1'b0, '0, '0);
		@(negedge tft_new_frame);
	endtask

	task automatic test_reset_state();
		check_flag("touched", 1'b0, touched);
		check_flag("press", 1'b0, press);
		check_flag("release_pulse", 1'b0, release_pulse);
		check_count("hold_frames", '0, hold_frames);
		step(12'd550, 12'd700, 12'd256);
		step(12'd550, 12'd700, 12'd256);
		// (550-150)>>2 and (700-300)>>2
		check_coord("cursor_x", 12'd100, cursor_x);
		check_coord("cursor_y", 12'd100, cursor_y);
		check_flag("touched", 1'b1, touched);
		step(12'd0, 12'd0, 12'd0);
		step(12'd0, 12'd0, 12'd0);
	endtask

	task automatic test_threshold();
		logic [31:0] r;
		step(12'd900, 12'd900, 12'd255);
		step(12'd1200, 12'd1300, 12'd256);
		// z one below threshold keeps the cursor on the earlier press
		check_flag("touched", 1'b0, touched);
		check_coord("cursor_x", 12'd100, cursor_x);
		step(12'd0, 12'd0, 12'd0);
		check_flag("touched", 1'b1, touched);
		check_coord("cursor_x", 12'd262, cursor_x);
		step(12'd0, 12'd0, 12'd0);
		// random points straddling the threshold
		repeat (40) begin
			r = next_random();
			step(r[11:0], r[23:12], r[24] ? 12'd256 + r[31:25] : 12'd255 - r[31:25]);
		end
	endtask

	task automatic test_hold_on_release();
		logic [31:0] r;
		step(12'd2000, 12'd1500, 12'd600);
		repeat (7) begin
			r = next_random();
			// raw position wanders while pressure stays low
			step(r[11:0], r[23:12], 12'd100);
			check_coord("cursor_x", 12'd462, cursor_x);
			check_coord("cursor_y", 12'd300, cursor_y);
		end
	endtask

	task automatic test_press_release();
		repeat (3) step(12'd0, 12'd0, 12'd0);
		press_seen = 0;
		release_seen = 0;
		hold_peak = '0;
		repeat (5) step(12'd800, 12'd800, 12'd400);
		repeat (4) step(12'd0, 12'd0, 12'd0);
		if (press_seen != 1 || release_seen != 1) begin
			errors++;
			$display("short touch gave %0d press and %0d release pulses, one each wanted",
				press_seen, release_seen);
		end
		check_count("hold_peak", 8'd5, hold_peak);
		check_count("hold_frames", '0, hold_frames);
		// long press pins the counter
		repeat (302) step(12'd800, 12'd800, 12'd400);
		check_count("hold_frames", 8'd255, hold_frames);
		repeat (3) step(12'd0, 12'd0, 12'd0);
		check_count("hold_frames", '0, hold_frames);
	endtask

	task automatic test_calibration();
		step(12'd0, 12'd0, 12'd0, 1'b1, CFG_ADDR_OFFSET_X, 12'd0);
		step(12'd0, 12'd0, 12'd0, 1'b1, CFG_ADDR_OFFSET_Y, 12'd0);
		step(12'd0, 12'd0, 12'd0, 1'b1, CFG_ADDR_SHIFT, 12'd0);
		step(12'd0, 12'd0, 12'd0, 1'b1, CFG_ADDR_THRESHOLD, 12'd16);
		step(12'd1234, 12'd567, 12'd20);
		step(12'd0, 12'd0, 12'd0);
		// identity mapping and weak touch now counts
		check_coord("cursor_x", 12'd1234, cursor_x);
		check_coord("cursor_y", 12'd567, cursor_y);
		check_flag("touched", 1'b1, touched);
		step(12'd0, 12'd0, 12'd0, 1'b1, CFG_ADDR_OFFSET_X, 12'd2000);
		// upper bits dropped leaving a shift of 1
		step(12'd0, 12'd0, 12'd0, 1'b1, CFG_ADDR_SHIFT, 12'h005);
		step(12'd100, 12'd50, 12'd20);
		step(12'd0, 12'd0, 12'd0);
		// (100-2000) mod 4096 = 2196 then >>1
		check_coord("cursor_x", 12'd1098, cursor_x);
		check_coord("cursor_y", 12'd25, cursor_y);
		repeat (4) step(12'd0, 12'd0, 12'd0);
	endtask

	// hung run guard
	initial begin
		#((TEST_FRAMES + MARGIN_FRAMES) * FRAME_NS);
		$display("timeout, the tests did not finish in the expected number of frames");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		touch_x = '0;
		touch_y = '0;
		touch_z = '0;
		cfg_write = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		press_seen = 0;
		release_seen = 0;
		hold_peak = '0;
		apply_reset();
		test_reset_state();
		test_threshold();
		test_hold_on_release();
		test_press_release();
		test_calibration();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
